// ==== rtl/cart_config.svh ====
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// ====================
// Download stream widths
// ====================
`define CART_DL_ADDR_W 25
`define CART_MASK_W 24
`define CART_FILL_ADDR_W 18

// ====================
// Cartridge header layout
// ====================
// Copier header ahead of the ROM image
`define CART_HDR_SKIP 512

// Word holding the ROM size byte, per mapping
`define CART_LOROM_SIZE_ADDR (32'h0000_7FD6 + `CART_HDR_SKIP)
`define CART_HIROM_SIZE_ADDR (32'h0000_FFD6 + `CART_HDR_SKIP)
`define CART_EXHIROM_SIZE_ADDR (32'h0040_FFD6 + `CART_HDR_SKIP)

// RAM size byte sits one word after the ROM size byte
`define CART_SIZE_TO_RAM_OFFS 2
`define CART_DEFAULT_ROM_SIZE 4'hC

// Smallest mapped block, 1 KiB
`define CART_MASK_UNIT 1024

// Download index values
`define CART_CODE_INDEX 8'hFF
`define CART_ROM_INDEX 6'h00

`endif

// ==== rtl/cart_pkg.sv ====
`default_nettype none

`include "cart_config.svh"

package cart_pkg;

	// Download stream
	typedef logic [15:0] dl_word_t;
	typedef logic [`CART_DL_ADDR_W-1:0] dl_addr_t;
	typedef logic [7:0] dl_index_t;

	// Header results
	typedef logic [`CART_MASK_W-1:0] mem_mask_t;
	typedef logic [7:0] byte_t;
	typedef logic [3:0] size_code_t;

	// RAM clear
	typedef logic [`CART_FILL_ADDR_W-1:0] fill_addr_t;

	// {flags, address, compare, replace}, 32 bits each
	typedef logic [127:0] cheat_code_t;

	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} hdr_mode_e;

	// Upper bit set means PAL for every forced choice
	typedef enum logic [1:0] {
		REG_AUTO    = 2'd0,
		REG_NTSC    = 2'd1,
		REG_PAL     = 2'd2,
		REG_PAL_ALT = 2'd3
	} region_sel_e;

	typedef enum logic [1:0] {
		PAT_9966 = 2'd0,
		PAT_00FF = 2'd1,
		PAT_55   = 2'd2,
		PAT_FF   = 2'd3
	} fill_pat_e;

	typedef enum logic [1:0] {
		FILL_IDLE  = 2'd0,
		FILL_WRITE = 2'd1,
		FILL_WAIT  = 2'd2
	} fill_state_e;

endpackage

`default_nettype wire

// ==== rtl/header_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cart_config.svh"

module header_detect (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   cart_dl,
	input  logic                   ioctl_wr,
	input  cart_pkg::dl_addr_t     ioctl_addr,
	input  cart_pkg::dl_word_t     ioctl_dout,
	input  cart_pkg::hdr_mode_e    header_mode,
	input  cart_pkg::region_sel_e  region_sel,
	output cart_pkg::byte_t        rom_type,
	output cart_pkg::mem_mask_t    rom_mask,
	output cart_pkg::mem_mask_t    ram_mask,
	output logic                   pal
);

	import cart_pkg::*;

	size_code_t rom_size;
	size_code_t ram_size;
	logic       rom_region;

	// Where the size bytes live for a forced mapping
	dl_addr_t   size_addr;
	dl_addr_t   ram_size_addr;
	logic       size_en;

	logic       hdr_wr;

	assign hdr_wr = cart_dl & ioctl_wr;

	always_comb begin
		size_en   = 1'b1;
		size_addr = dl_addr_t'(`CART_LOROM_SIZE_ADDR);
		case (header_mode)
			HDR_LOROM:   size_addr = dl_addr_t'(`CART_LOROM_SIZE_ADDR);
			HDR_HIROM:   size_addr = dl_addr_t'(`CART_HIROM_SIZE_ADDR);
			HDR_EXHIROM: size_addr = dl_addr_t'(`CART_EXHIROM_SIZE_ADDR);
			default:     size_en = 1'b0;
		endcase
	end

	assign ram_size_addr = size_addr + dl_addr_t'(`CART_SIZE_TO_RAM_OFFS);

	// ====================
	// Header capture
	// ====================
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			if (ioctl_addr == '0) begin
				rom_size <= `CART_DEFAULT_ROM_SIZE;
				ram_size <= '0;
				// Copier header byte carries both size codes
				if (header_mode == HDR_AUTO && ioctl_dout[7:0] != 8'h00) begin
					{ram_size, rom_size} <= ioctl_dout[7:0];
				end

				case (header_mode)
					HDR_NONE:    rom_type <= 8'd0;
					HDR_LOROM:   rom_type <= 8'd0;
					HDR_HIROM:   rom_type <= 8'd1;
					HDR_EXHIROM: rom_type <= 8'd2;
					default:     rom_type <= ioctl_dout[15:8];
				endcase
			end

			if (ioctl_addr == dl_addr_t'(2)) begin
				rom_region <= ioctl_dout[8];
			end

			// Internal header of the forced mapping
			if (size_en && ioctl_addr == size_addr) begin
				rom_size <= ioctl_dout[11:8];
			end
			if (size_en && ioctl_addr == ram_size_addr) begin
				ram_size <= ioctl_dout[3:0];
			end
		end
	end

	// ====================
	// Address masks
	// ====================
	assign rom_mask = (mem_mask_t'(`CART_MASK_UNIT) << rom_size) - mem_mask_t'(1);

	// No cartridge RAM at all for a zero code
	assign ram_mask = (ram_size == '0) ? '0 :
		(mem_mask_t'(`CART_MASK_UNIT) << ram_size) - mem_mask_t'(1);

	// Region only moves once the download is over
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			pal <= 1'b0;
		end else if (!cart_dl) begin
			if (region_sel == REG_AUTO)
				pal <= rom_region;
			else
				pal <= region_sel[1];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/ram_fill.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_fill (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  cart_dl,
	input  cart_pkg::fill_pat_e   wram_pattern,
	input  cart_pkg::fill_pat_e   aram_pattern,
	output cart_pkg::fill_addr_t  fill_addr,
	output logic                  fill_we,
	output logic                  clearing,
	output cart_pkg::byte_t       wram_fill_data,
	output cart_pkg::byte_t       aram_fill_data
);

	import cart_pkg::*;

	fill_state_e state;
	logic        cart_dl_d;
	logic        dl_start;

	// Start-up contents as left by the various console revisions
	function automatic byte_t fill_byte(input fill_pat_e pat, input fill_addr_t addr);
		byte_t val;
		case (pat)
			PAT_9966: val = (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
			PAT_00FF: val = (addr[9] ^ addr[0]) ? 8'hFF : 8'h00;
			PAT_55:   val = 8'h55;
			default:  val = 8'hFF;
		endcase
		return val;
	endfunction

	assign dl_start = cart_dl & ~cart_dl_d;

	// ====================
	// Clear sequencer
	// ====================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_d <= 1'b0;
			state     <= FILL_IDLE;
			fill_addr <= '0;
		end else begin
			cart_dl_d <= cart_dl;
			case (state)
				FILL_IDLE: begin
					if (dl_start) begin
						state     <= FILL_WRITE;
						fill_addr <= '0;
					end
				end
				FILL_WRITE: begin
					state <= FILL_WAIT;
				end
				FILL_WAIT: begin
					// Last location written, stop here
					if (&fill_addr) begin
						state <= FILL_IDLE;
					end else begin
						fill_addr <= fill_addr + fill_addr_t'(1);
						state     <= FILL_WRITE;
					end
				end
				default: state <= FILL_IDLE;
			endcase
		end
	end

	assign fill_we  = (state == FILL_WRITE);
	assign clearing = (state != FILL_IDLE);

	assign wram_fill_data = fill_byte(wram_pattern, fill_addr);
	assign aram_fill_data = fill_byte(aram_pattern, fill_addr);

endmodule

`default_nettype wire

// ==== rtl/cheat_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module cheat_assembler (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  code_dl,
	input  logic                  cart_dl,
	input  logic                  ioctl_wr,
	input  cart_pkg::dl_addr_t    ioctl_addr,
	input  cart_pkg::dl_word_t    ioctl_dout,
	output cart_pkg::cheat_code_t cheat_code,
	output logic                  cheat_strobe,
	output logic                  cheat_clear
);

	logic code_wr;

	assign code_wr = code_dl & ioctl_wr;

	// Eight 16-bit words per code, low half first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  cheat_code[111:96]  <= ioctl_dout;
				4'd2:  cheat_code[127:112] <= ioctl_dout;
				4'd4:  cheat_code[79:64]   <= ioctl_dout;
				4'd6:  cheat_code[95:80]   <= ioctl_dout;
				4'd8:  cheat_code[47:32]   <= ioctl_dout;
				4'd10: cheat_code[63:48]   <= ioctl_dout;
				4'd12: cheat_code[15:0]    <= ioctl_dout;
				4'd14: cheat_code[31:16]   <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// ====================
	// Load and flush pulses
	// ====================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_strobe <= 1'b0;
			cheat_clear  <= 1'b0;
		end else begin
			// Replace high word completes the code
			cheat_strobe <= code_wr && (ioctl_addr[3:0] == 4'd14);
			// A new code list or a new cartridge drops the old codes
			cheat_clear  <= (code_wr && ioctl_addr == '0) || cart_dl;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/core_reset_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_reset_gen (
	input  logic clk_sys,
	input  logic RESET,
	input  logic hold,
	output logic core_reset_n,
	output logic rfsh
);

	logic [1:0] phase;

	// ====================
	// Refresh phase divider
	// ====================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			phase        <= 2'd0;
			rfsh         <= 1'b0;
			core_reset_n <= 1'b0;
		end else begin
			phase <= phase + 2'd1;
			// High while the phase reads 0
			rfsh  <= (phase == 2'd3);

			// Release only at phase 2 so the core starts aligned to refresh
			if (phase == 2'd2) begin
				core_reset_n <= ~hold;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cart_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cart_config.svh"

module cart_loader (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   user_reset,

	// Host download stream
	input  logic                   ioctl_download,
	input  cart_pkg::dl_index_t    ioctl_index,
	input  cart_pkg::dl_addr_t     ioctl_addr,
	input  cart_pkg::dl_word_t     ioctl_dout,
	input  logic                   ioctl_wr,

	// Menu selections
	input  cart_pkg::hdr_mode_e    header_mode,
	input  cart_pkg::region_sel_e  region_sel,
	input  cart_pkg::fill_pat_e    wram_pattern,
	input  cart_pkg::fill_pat_e    aram_pattern,

	// Cartridge description
	output cart_pkg::byte_t        rom_type,
	output cart_pkg::mem_mask_t    rom_mask,
	output cart_pkg::mem_mask_t    ram_mask,
	output logic                   pal,

	// RAM clear port
	output cart_pkg::fill_addr_t   fill_addr,
	output logic                   fill_we,
	output logic                   clearing,
	output cart_pkg::byte_t        wram_fill_data,
	output cart_pkg::byte_t        aram_fill_data,

	// Cheat engine
	output cart_pkg::cheat_code_t  cheat_code,
	output logic                   cheat_strobe,
	output logic                   cheat_clear,

	// Core control
	output logic                   core_reset_n,
	output logic                   rfsh
);

	logic cart_dl;
	logic code_dl;
	logic hold;

	// ====================
	// Download decode
	// ====================
	// Only the low six index bits select the ROM slot
	assign cart_dl = ioctl_download && (ioctl_index[5:0] == `CART_ROM_INDEX);
	assign code_dl = ioctl_download && (ioctl_index == `CART_CODE_INDEX);

	// Core stays in reset while anything rewrites its memories
	assign hold = user_reset | cart_dl | clearing;

	header_detect i_header_detect (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cart_dl     (cart_dl),
		.ioctl_wr    (ioctl_wr),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.rom_type    (rom_type),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.pal         (pal)
	);

	ram_fill i_ram_fill (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.cart_dl        (cart_dl),
		.wram_pattern   (wram_pattern),
		.aram_pattern   (aram_pattern),
		.fill_addr      (fill_addr),
		.fill_we        (fill_we),
		.clearing       (clearing),
		.wram_fill_data (wram_fill_data),
		.aram_fill_data (aram_fill_data)
	);

	cheat_assembler i_cheat_assembler (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.code_dl      (code_dl),
		.cart_dl      (cart_dl),
		.ioctl_wr     (ioctl_wr),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.cheat_code   (cheat_code),
		.cheat_strobe (cheat_strobe),
		.cheat_clear  (cheat_clear)
	);

	core_reset_gen i_core_reset_gen (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.hold         (hold),
		.core_reset_n (core_reset_n),
		.rfsh         (rfsh)
	);

endmodule

`default_nettype wire

// ==== bench/cart_loader_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_loader_assert (
	input logic clk_sys,
	input logic RESET,
	input logic fill_we,
	input logic clearing,
	input logic cheat_strobe,
	input logic core_reset_n
);

	int assert_errors = 0;

	// ====================
	// RAM clear writes
	// ====================
	// Writes come every second cycle until the clear ends
	a_fill_we_rhythm: assert property (@(posedge clk_sys) disable iff (RESET)
		fill_we |=> ##1 (fill_we || !clearing)) else begin
		$error("RAM clear write missing two cycles after the previous one");
		assert_errors++;
	end

	a_fill_we_spaced: assert property (@(posedge clk_sys) disable iff (RESET)
		fill_we |=> !fill_we) else begin
		$error("fill_we high on two cycles in a row");
		assert_errors++;
	end

	a_strobe_single: assert property (@(posedge clk_sys) disable iff (RESET)
		cheat_strobe |=> !cheat_strobe) else begin
		$error("cheat_strobe longer than one cycle");
		assert_errors++;
	end

	// Core held in reset soon after a clear starts
	a_reset_on_clear: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(clearing) |-> ##4 !core_reset_n) else begin
		$error("core_reset_n still high four cycles into a RAM clear");
		assert_errors++;
	end

endmodule

`default_nettype wire

// ==== bench/tb_cart_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cart_config.svh"

module tb_cart_loader;

	import cart_pkg::*;

	localparam int TIMEOUT_CYCLES = 4000000;
	localparam int FILL_WORDS = 1 << `CART_FILL_ADDR_W;

	logic        clk_sys;
	logic        RESET;
	logic        user_reset;
	logic        ioctl_download;
	dl_index_t   ioctl_index;
	dl_addr_t    ioctl_addr;
	dl_word_t    ioctl_dout;
	logic        ioctl_wr;
	hdr_mode_e   header_mode;
	region_sel_e region_sel;
	fill_pat_e   wram_pattern;
	fill_pat_e   aram_pattern;
	byte_t       rom_type;
	mem_mask_t   rom_mask;
	mem_mask_t   ram_mask;
	logic        pal;
	fill_addr_t  fill_addr;
	logic        fill_we;
	logic        clearing;
	byte_t       wram_fill_data;
	byte_t       aram_fill_data;
	cheat_code_t cheat_code;
	logic        cheat_strobe;
	logic        cheat_clear;
	logic        core_reset_n;
	logic        rfsh;

	logic [31:0] lfsr;
	int          cycles = 0;
	fill_addr_t  fill_next = '0;
	int          fill_count = 0;
	int          strobe_count = 0;
	cheat_code_t strobe_code;
	logic        clear_seen = 1'b0;
	logic [3:0]  hold_hist = 4'b1111;
	int          rfsh_gap = 0;
	logic        rfsh_seen = 1'b0;

	// Clear window model
	int          clear_left = 0;
	logic        dl_prev = 1'b0;
	logic        dl_now;
	logic        clear_now;

	// Header model state
	size_code_t  exp_rom_size;
	size_code_t  exp_ram_size;
	byte_t       exp_type;
	logic        exp_region;

	cart_loader i_cart_loader (.*);

	// ====================
	// Models
	// ====================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	function automatic mem_mask_t mask_model(input size_code_t code);
		longint span;
		span = longint'(`CART_MASK_UNIT) << code;
		return mem_mask_t'(span - 1);
	endfunction

	function automatic byte_t fill_model(input fill_pat_e pat, input fill_addr_t a);
		case (pat)
			PAT_9966: return (a[8] != a[2]) ? 8'h66 : 8'h99;
			PAT_00FF: return (a[9] != a[0]) ? 8'hFF : 8'h00;
			PAT_55:   return 8'h55;
			default:  return 8'hFF;
		endcase
	endfunction

	function automatic dl_addr_t size_addr_of(input hdr_mode_e mode);
		case (mode)
			HDR_HIROM:   return dl_addr_t'(`CART_HIROM_SIZE_ADDR);
			HDR_EXHIROM: return dl_addr_t'(`CART_EXHIROM_SIZE_ADDR);
			default:     return dl_addr_t'(`CART_LOROM_SIZE_ADDR);
		endcase
	endfunction

	// ====================
	// Checks
	// ====================
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp)
			fail_run($sformatf("MISMATCH %s expected %02h actual %02h", name, exp, act));
	endtask

	task automatic check_mask(input string name, input mem_mask_t exp, input mem_mask_t act);
		if (act !== exp)
			fail_run($sformatf("MISMATCH %s expected %06h actual %06h", name, exp, act));
	endtask

	task automatic check_addr(input string name, input fill_addr_t exp, input fill_addr_t act);
		if (act !== exp)
			fail_run($sformatf("MISMATCH %s expected %05h actual %05h", name, exp, act));
	endtask

	task automatic check_code(input string name, input cheat_code_t exp, input cheat_code_t act);
		if (act !== exp)
			fail_run($sformatf("MISMATCH %s expected %032h actual %032h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			fail_run("Timeout: the tests did not finish within the cycle limit");
	end

	// Outputs are sampled mid-cycle, away from both edges
	always @(negedge clk_sys) begin
		if (i_cart_loader.i_cart_loader_assert.assert_errors != 0)
			fail_run("A bound assertion failed");
		if (fill_we) begin
			check_addr("fill_addr", fill_next, fill_addr);
			check_byte("wram_fill_data", fill_model(wram_pattern, fill_next), wram_fill_data);
			check_byte("aram_fill_data", fill_model(aram_pattern, fill_next), aram_fill_data);
			fill_next = fill_next + fill_addr_t'(1);
			fill_count = fill_count + 1;
		end
		if (cheat_strobe) begin
			strobe_count = strobe_count + 1;
			strobe_code = cheat_code;
		end
		if (cheat_clear)
			clear_seen = 1'b1;
		// A rising cartridge download while idle opens two cycles per fill address
		dl_now = ioctl_download && (ioctl_index[5:0] == `CART_ROM_INDEX);
		clear_now = (clear_left > 0);
		check_bit("clearing", clear_now, clearing);
		if (clear_now)
			clear_left = clear_left - 1;
		else if (dl_now && !dl_prev)
			clear_left = 2 * FILL_WORDS;
		dl_prev = dl_now;
		// Four steady hold samples always span one release edge
		if (hold_hist == 4'b1111)
			check_bit("core_reset_n while held", 1'b0, core_reset_n);
		else if (hold_hist == 4'b0000)
			check_bit("core_reset_n after release", 1'b1, core_reset_n);
		hold_hist = {hold_hist[2:0], RESET | user_reset | clear_now | dl_now};
		if (!RESET) begin
			if (rfsh_seen)
				check_bit("rfsh period", rfsh_gap == 3, rfsh);
			if (rfsh) begin
				rfsh_seen = 1'b1;
				rfsh_gap = 0;
			end else begin
				rfsh_gap = rfsh_gap + 1;
			end
		end
	end

	// ====================
	// Stimulus
	// ====================
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic write_word(input dl_addr_t addr, input dl_word_t data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		next_cycle();
		ioctl_wr = 1'b0;
		next_cycle();
	endtask

	task automatic header_write(input dl_addr_t addr, input dl_word_t data);
		if (addr == '0) begin
			exp_rom_size = `CART_DEFAULT_ROM_SIZE;
			exp_ram_size = 4'h0;
			if (header_mode == HDR_AUTO && data[7:0] != 8'h00) begin
				exp_rom_size = data[3:0];
				exp_ram_size = data[7:4];
			end
			case (header_mode)
				HDR_HIROM:   exp_type = 8'd1;
				HDR_EXHIROM: exp_type = 8'd2;
				HDR_AUTO:    exp_type = data[15:8];
				default:     exp_type = 8'd0;
			endcase
		end
		if (addr == dl_addr_t'(2))
			exp_region = data[8];
		if (header_mode != HDR_AUTO && header_mode != HDR_NONE) begin
			if (addr == size_addr_of(header_mode))
				exp_rom_size = data[11:8];
			if (addr == size_addr_of(header_mode) + dl_addr_t'(`CART_SIZE_TO_RAM_OFFS))
				exp_ram_size = data[3:0];
		end
		write_word(addr, data);
	endtask

	// Header words of one cartridge, then the full RAM clear it starts
	task automatic cart_download(input hdr_mode_e mode, input logic zero_low);
		logic [31:0] r;
		dl_word_t    w;
		header_mode = mode;
		r = rand_bits(6);
		wram_pattern = fill_pat_e'(r[1:0]);
		aram_pattern = fill_pat_e'(r[3:2]);
		fill_next = '0;
		fill_count = 0;
		ioctl_index = {r[5:4], `CART_ROM_INDEX};
		ioctl_download = 1'b1;
		next_cycle();
		next_cycle();
		check_bit("cheat_clear during cartridge download", 1'b1, cheat_clear);
		w = dl_word_t'(rand_bits(16));
		if (zero_low)
			w[7:0] = 8'h00;
		header_write('0, w);
		header_write(dl_addr_t'(2), dl_word_t'(rand_bits(16)));
		// Forced none still gets size words, which must be ignored
		if (mode != HDR_AUTO) begin
			header_write(size_addr_of(mode), dl_word_t'(rand_bits(16)));
			w = dl_word_t'(rand_bits(16));
			if (mode == HDR_HIROM)
				w[3:0] = 4'h0;
			header_write(size_addr_of(mode) + dl_addr_t'(`CART_SIZE_TO_RAM_OFFS), w);
		end
		ioctl_download = 1'b0;
		next_cycle();
		check_byte("rom_type", exp_type, rom_type);
		check_mask("rom_mask", mask_model(exp_rom_size), rom_mask);
		check_mask("ram_mask", (exp_ram_size == 4'h0) ? '0 : mask_model(exp_ram_size), ram_mask);
		for (int s = 0; s < 4; s++) begin
			region_sel = region_sel_e'(2'(s));
			next_cycle();
			next_cycle();
			check_bit("pal", (s == 0) ? exp_region : s[1], pal);
		end
		while (fill_count < FILL_WORDS)
			next_cycle();
		for (int i = 0; i < 4 && clearing; i++)
			next_cycle();
		if (clearing)
			fail_run("clearing stayed high after the last RAM clear write");
		if (fill_count != FILL_WORDS)
			fail_run($sformatf("RAM clear wrote %0d words instead of %0d", fill_count, FILL_WORDS));
	endtask

	task automatic cheat_download();
		logic [31:0] r;
		dl_word_t    words [8];
		int          order [7];
		int          j;
		int          t;
		cheat_code_t exp_code;
		for (int i = 0; i < 8; i++)
			words[i] = dl_word_t'(rand_bits(16));
		for (int i = 0; i < 7; i++)
			order[i] = 2 * i;
		// Shuffle the first seven word addresses, address 14 stays last
		for (int i = 6; i > 0; i--) begin
			r = rand_bits(3);
			j = int'(r[2:0]) % (i + 1);
			t = order[i];
			order[i] = order[j];
			order[j] = t;
		end
		exp_code = {words[1], words[0], words[3], words[2], words[5], words[4], words[7], words[6]};
		strobe_count = 0;
		clear_seen = 1'b0;
		ioctl_index = `CART_CODE_INDEX;
		ioctl_download = 1'b1;
		next_cycle();
		for (int i = 0; i < 8; i++) begin
			j = (i < 7) ? order[i] : 14;
			if (j == 0)
				check_bit("cheat_clear before code word 0", 1'b0, clear_seen);
			write_word(dl_addr_t'(j), words[j / 2]);
			if (j == 0)
				check_bit("cheat_clear after code word 0", 1'b1, clear_seen);
		end
		ioctl_download = 1'b0;
		repeat (3) next_cycle();
		if (strobe_count != 1)
			fail_run($sformatf("Expected one cheat_strobe but saw %0d", strobe_count));
		check_code("cheat_code", exp_code, strobe_code);
	endtask

	task automatic user_reset_test();
		user_reset = 1'b1;
		repeat (20) next_cycle();
		check_bit("core_reset_n under user_reset", 1'b0, core_reset_n);
		user_reset = 1'b0;
		repeat (6) next_cycle();
		check_bit("core_reset_n after user_reset", 1'b1, core_reset_n);
	endtask

	initial begin
		lfsr = 32'hb7f1_1555;
		RESET = 1'b1;
		user_reset = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_wr = 1'b0;
		header_mode = HDR_AUTO;
		region_sel = REG_AUTO;
		wram_pattern = PAT_9966;
		aram_pattern = PAT_9966;
		repeat (10) @(posedge clk_sys);
		#1;
		RESET = 1'b0;
		next_cycle();
		cart_download(HDR_AUTO, 1'b0);
		cart_download(HDR_AUTO, 1'b1);
		cart_download(HDR_NONE, 1'b0);
		cart_download(HDR_LOROM, 1'b0);
		cart_download(HDR_HIROM, 1'b0);
		cart_download(HDR_EXHIROM, 1'b0);
		cheat_download();
		user_reset_test();
		$display("Result: PASSED");
		$finish;
	end

endmodule

bind cart_loader cart_loader_assert i_cart_loader_assert (
	.clk_sys      (clk_sys),
	.RESET        (RESET),
	.fill_we      (fill_we),
	.clearing     (clearing),
	.cheat_strobe (cheat_strobe),
	.core_reset_n (core_reset_n)
);

`default_nettype wire

// ==== all.f ====
+incdir+rtl
rtl/cart_pkg.sv
rtl/header_detect.sv
rtl/ram_fill.sv
rtl/cheat_assembler.sv
rtl/core_reset_gen.sv
rtl/cart_loader.sv
bench/cart_loader_assert.sv
bench/tb_cart_loader.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cart_loader testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module tb_cart_loader \
	-Mdir obj_dir > build.log 2>&1 &&
	./obj_dir/Vtb_cart_loader > sim.log 2>&1 ||
	echo "Build or simulation ended with an error"
grep -q "Result: PASSED" sim.log && echo "Simulation passed" || {
	echo "Simulation failed, see build.log and sim.log"
	exit 1
}
